//--- source/clock_pkg.sv
// Shared clock types: modes, field positions, time struct, field limits, segment table
`default_nettype none

package clock_pkg;

	// Mode order follows the mode button: clock, setup, alarm
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	// Field selected by the position button
	typedef enum logic [1:0] {
		POS_SEC  = 2'd0,
		POS_MIN  = 2'd1,
		POS_HOUR = 2'd2
	} pos_t;

	typedef struct packed {
		logic [5:0] hour;
		logic [5:0] min;
		logic [5:0] sec;
	} time_t;

	// Bit 6 is segment a, bit 0 is segment g, active high
	typedef logic [6:0] seg_t;

	parameter logic [5:0] SEC_MAX  = 6'd59;
	parameter logic [5:0] HOUR_MAX = 6'd23;
	parameter int NUM_DIGITS = 6;

	// Patterns for 0 to 9
	parameter seg_t DIGIT_SEGS [10] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};

endpackage

`default_nettype wire

//--- source/time_set_if.sv
// Run and field-step enables from the mode FSM to one time keeper
`timescale 1ns/1ps
`default_nettype none

interface time_set_if;

	// High lets second ticks advance the keeper
	logic run;

	// One-cycle step pulses, one field each, no carry
	logic inc_sec;
	logic inc_min;
	logic inc_hour;

	modport fsm (
		output run,
		output inc_sec,
		output inc_min,
		output inc_hour
	);

	modport keeper (
		input run,
		input inc_sec,
		input inc_min,
		input inc_hour
	);

endinterface

`default_nettype wire

//--- source/tick_timer.sv
// Clock-enable divider giving a one-cycle tick every DIV cycles
`timescale 1ns/1ps
`default_nettype none

module tick_timer #(
	parameter int DIV = 50_000_000
) (
	input  wire  clk,
	input  wire  rst_n,
	output logic o_tick
);

	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIV - 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (cnt == CNT_LAST) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Tick is sampled at the edge that wraps the counter
	assign o_tick = (cnt == CNT_LAST);

	a_tick_single : assert property (@(posedge clk) disable iff (!rst_n)
		(DIV > 1) && o_tick |=> !o_tick);

endmodule

`default_nettype wire

//--- source/clock_mode_fsm.sv
// Mode, field position and alarm-enable state with tick and step steering
`timescale 1ns/1ps
`default_nettype none

module clock_mode_fsm (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        i_sw_mode,
	input  wire        i_sw_pos,
	input  wire        i_sw_inc,
	input  wire        i_sw_alarm,
	output logic       o_show_alarm,
	output logic       o_alarm_en,
	time_set_if.fsm    time_set,
	time_set_if.fsm    alarm_set
);

	clock_pkg::mode_t mode;
	clock_pkg::pos_t  pos;
	logic             inc_q;

	// ----------------------------------------------------------------------
	// Button state
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode       <= clock_pkg::MODE_CLOCK;
			pos        <= clock_pkg::POS_SEC;
			o_alarm_en <= 1'b0;
			inc_q      <= 1'b0;
		end else begin
			inc_q <= i_sw_inc;
			if (i_sw_mode) begin
				case (mode)
					clock_pkg::MODE_CLOCK: mode <= clock_pkg::MODE_SETUP;
					clock_pkg::MODE_SETUP: mode <= clock_pkg::MODE_ALARM;
					default:               mode <= clock_pkg::MODE_CLOCK;
				endcase
			end
			if (i_sw_pos) begin
				case (pos)
					clock_pkg::POS_SEC: pos <= clock_pkg::POS_MIN;
					clock_pkg::POS_MIN: pos <= clock_pkg::POS_HOUR;
					default:            pos <= clock_pkg::POS_SEC;
				endcase
			end
			if (i_sw_alarm) begin
				o_alarm_en <= ~o_alarm_en;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Steering
	// ----------------------------------------------------------------------
	// Time is frozen only while it is being set
	assign time_set.run  = (mode != clock_pkg::MODE_SETUP);
	assign alarm_set.run = 1'b0;

	assign time_set.inc_sec   = inc_q && (mode == clock_pkg::MODE_SETUP) &&
		(pos == clock_pkg::POS_SEC);
	assign time_set.inc_min   = inc_q && (mode == clock_pkg::MODE_SETUP) &&
		(pos == clock_pkg::POS_MIN);
	assign time_set.inc_hour  = inc_q && (mode == clock_pkg::MODE_SETUP) &&
		(pos == clock_pkg::POS_HOUR);

	assign alarm_set.inc_sec  = inc_q && (mode == clock_pkg::MODE_ALARM) &&
		(pos == clock_pkg::POS_SEC);
	assign alarm_set.inc_min  = inc_q && (mode == clock_pkg::MODE_ALARM) &&
		(pos == clock_pkg::POS_MIN);
	assign alarm_set.inc_hour = inc_q && (mode == clock_pkg::MODE_ALARM) &&
		(pos == clock_pkg::POS_HOUR);

	assign o_show_alarm = (mode == clock_pkg::MODE_ALARM);

	a_mode_legal : assert property (@(posedge clk) disable iff (!rst_n)
		mode inside {clock_pkg::MODE_CLOCK, clock_pkg::MODE_SETUP, clock_pkg::MODE_ALARM});

endmodule

`default_nettype wire

//--- source/time_keeper.sv
// Hours, minutes and seconds registers with tick carry and per-field steps
`timescale 1ns/1ps
`default_nettype none

module time_keeper (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              i_tick,
	time_set_if.keeper       ctrl,
	output clock_pkg::time_t o_time
);

	logic sec_last;
	logic min_last;

	// Next value of one field, back to zero past its limit
	function automatic logic [5:0] wrap_inc(input logic [5:0] value, input logic [5:0] limit);
		return (value == limit) ? 6'd0 : value + 6'd1;
	endfunction

	assign sec_last = (o_time.sec == clock_pkg::SEC_MAX);
	assign min_last = (o_time.min == clock_pkg::SEC_MAX);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_time <= '0;
		end else if (ctrl.run && i_tick) begin
			// Carries ripple through all fields in one edge
			o_time.sec <= wrap_inc(o_time.sec, clock_pkg::SEC_MAX);
			if (sec_last) begin
				o_time.min <= wrap_inc(o_time.min, clock_pkg::SEC_MAX);
				if (min_last) begin
					o_time.hour <= wrap_inc(o_time.hour, clock_pkg::HOUR_MAX);
				end
			end
		end else begin
			// Steps touch one field only
			if (ctrl.inc_sec) begin
				o_time.sec <= wrap_inc(o_time.sec, clock_pkg::SEC_MAX);
			end
			if (ctrl.inc_min) begin
				o_time.min <= wrap_inc(o_time.min, clock_pkg::SEC_MAX);
			end
			if (ctrl.inc_hour) begin
				o_time.hour <= wrap_inc(o_time.hour, clock_pkg::HOUR_MAX);
			end
		end
	end

	a_sec_range : assert property (@(posedge clk) disable iff (!rst_n)
		o_time.sec <= clock_pkg::SEC_MAX);
	a_min_range : assert property (@(posedge clk) disable iff (!rst_n)
		o_time.min <= clock_pkg::SEC_MAX);
	a_hour_range : assert property (@(posedge clk) disable iff (!rst_n)
		o_time.hour <= clock_pkg::HOUR_MAX);

endmodule

`default_nettype wire

//--- source/alarm_match.sv
// Alarm compare with a level that holds until the alarm is disabled
`timescale 1ns/1ps
`default_nettype none

module alarm_match (
	input  wire              clk,
	input  wire              rst_n,
	input  wire clock_pkg::time_t i_time,
	input  wire clock_pkg::time_t i_alarm_time,
	input  wire              i_alarm_en,
	output logic             o_alarm
);

	logic time_hit;

	assign time_hit = (i_time == i_alarm_time);

	// Set on a match, held while enabled, cleared by the enable
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en && (time_hit || o_alarm);
		end
	end

endmodule

`default_nettype wire

//--- source/seg_scan.sv
// Digit split, segment decode and six-digit display scan
`timescale 1ns/1ps
`default_nettype none

module seg_scan #(
	parameter int SCAN_DIV = 5_000
) (
	input  wire                                 clk,
	input  wire                                 rst_n,
	input  wire clock_pkg::time_t               i_time,
	input  wire clock_pkg::time_t               i_alarm_time,
	input  wire                                 i_show_alarm,
	output clock_pkg::seg_t                     o_seg,
	output logic [clock_pkg::NUM_DIGITS-1:0]    o_seg_enb
);

	localparam int IDX_W = $clog2(clock_pkg::NUM_DIGITS);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(clock_pkg::NUM_DIGITS - 1);

	logic             scan_tick;
	logic [IDX_W-1:0] idx;
	clock_pkg::time_t shown;
	logic [3:0]       digits [clock_pkg::NUM_DIGITS];

	tick_timer #(
		.DIV    (SCAN_DIV)
	) u_scan_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	// ----------------------------------------------------------------------
	// Digit index
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= '0;
		end else if (scan_tick) begin
			idx <= (idx == IDX_LAST) ? '0 : idx + 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// Digit values and decode
	// ----------------------------------------------------------------------
	assign shown = i_show_alarm ? i_alarm_time : i_time;

	// Ones digit below tens for each field
	always_comb begin
		digits[0] = 4'(shown.sec % 6'd10);
		digits[1] = 4'(shown.sec / 6'd10);
		digits[2] = 4'(shown.min % 6'd10);
		digits[3] = 4'(shown.min / 6'd10);
		digits[4] = 4'(shown.hour % 6'd10);
		digits[5] = 4'(shown.hour / 6'd10);
	end

	assign o_seg     = clock_pkg::DIGIT_SEGS[digits[idx]];
	assign o_seg_enb = ~(clock_pkg::NUM_DIGITS'(1) << idx);

	a_enb_onehot : assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb));

endmodule

`default_nettype wire

//--- source/digital_clock_top.sv
// Clock top: second tick, mode FSM, time and alarm keepers, alarm compare, display scan
`timescale 1ns/1ps
`default_nettype none

module digital_clock_top #(
	parameter int TICK_DIV = 50_000_000,
	parameter int SCAN_DIV = 5_000
) (
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire                               i_sw_mode,
	input  wire                               i_sw_pos,
	input  wire                               i_sw_inc,
	input  wire                               i_sw_alarm,
	output clock_pkg::seg_t                   o_seg,
	output logic [clock_pkg::NUM_DIGITS-1:0]  o_seg_enb,
	output logic                              o_alarm
);

	logic             sec_tick;
	logic             show_alarm;
	logic             alarm_en;
	clock_pkg::time_t cur_time;
	clock_pkg::time_t alarm_time;

	time_set_if time_set ();
	time_set_if alarm_set ();

	tick_timer #(
		.DIV (TICK_DIV)
	) u_sec_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	clock_mode_fsm u_mode_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_sw_mode    (i_sw_mode),
		.i_sw_pos     (i_sw_pos),
		.i_sw_inc     (i_sw_inc),
		.i_sw_alarm   (i_sw_alarm),
		.o_show_alarm (show_alarm),
		.o_alarm_en   (alarm_en),
		.time_set     (time_set),
		.alarm_set    (alarm_set)
	);

	// Running time
	time_keeper u_time_keeper (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_tick (sec_tick),
		.ctrl   (time_set),
		.o_time (cur_time)
	);

	// Alarm time, never run by ticks
	time_keeper u_alarm_keeper (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_tick (sec_tick),
		.ctrl   (alarm_set),
		.o_time (alarm_time)
	);

	alarm_match u_alarm_match (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_time       (cur_time),
		.i_alarm_time (alarm_time),
		.i_alarm_en   (alarm_en),
		.o_alarm      (o_alarm)
	);

	seg_scan #(
		.SCAN_DIV (SCAN_DIV)
	) u_seg_scan (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_time       (cur_time),
		.i_alarm_time (alarm_time),
		.i_show_alarm (show_alarm),
		.o_seg        (o_seg),
		.o_seg_enb    (o_seg_enb)
	);

endmodule

`default_nettype wire

//--- test/tb_digital_clock.sv
// Testbench for the digital clock: clock, reset, vector reader, display decoder, checks
`timescale 1ns/1ps
`default_nettype none

module tb_digital_clock;

	localparam int TICK_DIV      = 40;
	localparam int SCAN_DIV      = 2;
	localparam int NUM_DIGITS    = 6;
	// Cycles taken by one display check, scan included
	localparam int CHECK_SPAN    = 24;
	localparam int DIGIT_TIMEOUT = 2 * SCAN_DIV * NUM_DIGITS + 2;
	localparam int MODE_SETUP    = 1;
	localparam int BTN_MODE      = 0;
	localparam int BTN_POS       = 1;
	localparam int BTN_INC       = 2;
	localparam int BTN_ALARM     = 3;

	logic       clk;
	logic       rst_n;
	logic       i_sw_mode;
	logic       i_sw_pos;
	logic       i_sw_inc;
	logic       i_sw_alarm;
	logic [6:0] o_seg;
	logic [5:0] o_seg_enb;
	logic       o_alarm;

	// Edges since reset release, and the mode expected from the presses so far
	int cycle;
	int mode_m;

	digital_clock_top #(
		.TICK_DIV (TICK_DIV),
		.SCAN_DIV (SCAN_DIV)
	) dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_sw_mode  (i_sw_mode),
		.i_sw_pos   (i_sw_pos),
		.i_sw_inc   (i_sw_inc),
		.i_sw_alarm (i_sw_alarm),
		.o_seg      (o_seg),
		.o_seg_enb  (o_seg_enb),
		.o_alarm    (o_alarm)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cycle <= 0;
		end else begin
			cycle <= cycle + 1;
		end
	end

	// ----------------------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------------------
	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic compare_value(input string name, input int got, input int expected);
		if (got != expected) begin
			$display("FAIL time=%0t %s got=%0d expected=%0d", $time, name, got, expected);
			abort_run();
		end
	endtask

	// Inputs move 1 ns after the rising edge
	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	// Standard seven-segment shapes, a in bit 6
	function automatic int seg_to_digit(input logic [6:0] seg);
		case (seg)
			7'h7E:   return 0;
			7'h30:   return 1;
			7'h6D:   return 2;
			7'h79:   return 3;
			7'h33:   return 4;
			7'h5B:   return 5;
			7'h5F:   return 6;
			7'h70:   return 7;
			7'h7F:   return 8;
			7'h73:   return 9;
			default: return -1;
		endcase
	endfunction

	task automatic press_button(input int which, input int count);
		for (int n = 0; n < count; n++) begin
			i_sw_mode  = (which == BTN_MODE);
			i_sw_pos   = (which == BTN_POS);
			i_sw_inc   = (which == BTN_INC);
			i_sw_alarm = (which == BTN_ALARM);
			step_cycle();
			i_sw_mode  = 1'b0;
			i_sw_pos   = 1'b0;
			i_sw_inc   = 1'b0;
			i_sw_alarm = 1'b0;
			step_cycle();
			if (which == BTN_MODE) begin
				mode_m = (mode_m + 1) % 3;
			end
		end
	endtask

	task automatic wait_digit(input int d);
		logic [5:0] want;
		int         waited;
		want   = ~(6'b000001 << d);
		waited = 0;
		while (o_seg_enb != want) begin
			step_cycle();
			waited++;
			if (waited > DIGIT_TIMEOUT) begin
				$display("Error at %0t: digit %0d was never enabled by the scan", $time, d);
				abort_run();
			end
		end
	endtask

	task automatic check_display(input int hh, input int mm, input int ss, input int al);
		int start;
		int next_tick;
		int expected [NUM_DIGITS];
		start     = cycle;
		next_tick = (cycle / TICK_DIV + 1) * TICK_DIV;
		// Running time must hold still for the whole scan
		if (mode_m != MODE_SETUP && next_tick - start <= CHECK_SPAN + 1) begin
			$display("Error at %0t: check at cycle %0d is too close to a second tick",
				$time, start);
			abort_run();
		end
		expected[0] = ss % 10;
		expected[1] = ss / 10;
		expected[2] = mm % 10;
		expected[3] = mm / 10;
		expected[4] = hh % 10;
		expected[5] = hh / 10;
		for (int d = 0; d < NUM_DIGITS; d++) begin
			wait_digit(d);
			compare_value($sformatf("o_seg digit %0d", d), seg_to_digit(o_seg), expected[d]);
		end
		compare_value("o_alarm", int'(o_alarm), al);
		while (cycle < start + CHECK_SPAN) begin
			step_cycle();
		end
	endtask

	// ----------------------------------------------------------------------
	// Vector reader
	// ----------------------------------------------------------------------
	initial begin
		int            fd;
		int            code;
		int            count;
		int            hh;
		int            mm;
		int            ss;
		int            al;
		logic [63:0]   op;
		logic [1023:0] rest;
		logic          done;
		rst_n      = 1'b0;
		i_sw_mode  = 1'b0;
		i_sw_pos   = 1'b0;
		i_sw_inc   = 1'b0;
		i_sw_alarm = 1'b0;
		mode_m     = 0;
		done       = 1'b0;
		fd = $fopen("test/clock_vectors.txt", "r");
		if (fd == 0) begin
			$display("Error: the vector file could not be opened");
			abort_run();
		end
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		while (!done) begin
			code = $fscanf(fd, "%s", op);
			if (code != 1) begin
				done = 1'b1;
			end else if (op == 64'("#")) begin
				code = $fgets(rest, fd);
			end else if (op == 64'("check")) begin
				code = $fscanf(fd, "%d %d %d %d", hh, mm, ss, al);
				if (code != 4) begin
					$display("Error: a check line in the vector file is incomplete");
					abort_run();
				end
				check_display(hh, mm, ss, al);
			end else begin
				code = $fscanf(fd, "%d", count);
				if (code != 1) begin
					$display("Error: a vector line has no count");
					abort_run();
				end
				if (op == 64'("wait")) begin
					repeat (count) step_cycle();
				end else if (op == 64'("mode")) begin
					press_button(BTN_MODE, count);
				end else if (op == 64'("pos")) begin
					press_button(BTN_POS, count);
				end else if (op == 64'("inc")) begin
					press_button(BTN_INC, count);
				end else if (op == 64'("alarm")) begin
					press_button(BTN_ALARM, count);
				end else begin
					$display("Error: unknown operation %0s in the vector file", op);
					abort_run();
				end
			end
		end
		$fclose(fd);
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/clock_vectors.txt
# Columns: operation (mode pos inc alarm wait check), then a press count or cycle count,
# or for check the expected hours, minutes, seconds and alarm level; one tick per 40 cycles
# After reset
check 0 0 0 0
wait 21
check 0 0 1 0
# Run past a minute, then freeze in setup
wait 2391
mode 1
check 0 1 1 0
# Seconds wrap without carry
inc 58
check 0 1 59 0
inc 1
check 0 1 0 0
# Minutes, then hours wrap after 23
pos 1
inc 2
check 0 3 0 0
pos 1
inc 23
check 23 3 0 0
inc 2
check 1 3 0 0
# Alarm mode shows and steps the alarm time
pos 1
mode 1
wait 15
check 0 0 0 0
inc 5
pos 1
inc 3
pos 1
inc 1
check 1 3 5 0
# Back to clock mode, running time untouched by alarm steps
mode 1
wait 8
check 1 3 3 0
# Enable the alarm and wait for the match
alarm 1
wait 14
check 1 3 4 0
wait 22
check 1 3 5 1
wait 50
check 1 3 7 1
# Disable clears the alarm level
alarm 1
wait 15
check 1 3 8 0

//--- tb.f
source/clock_pkg.sv
source/time_set_if.sv
source/tick_timer.sv
source/clock_mode_fsm.sv
source/time_keeper.sv
source/alarm_match.sv
source/seg_scan.sv
source/digital_clock_top.sv
test/tb_digital_clock.sv

//--- Makefile
# Verilator build and run for the digital clock testbench

VERILATOR ?= verilator
TOP       ?= tb_digital_clock
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard source/*.sv) $(wildcard test/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	$(BIN) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
